// File: hdl/ramPkg.sv
// bus package: address and data types, write-size codes, request and response structs
package ramPkg;

    // byte address as seen by every master
    typedef logic [23:0] ramAddr;

    // one memory word, byte 0 in bits 7:0
    typedef logic [31:0] ramData;

    // write size code carried with a write strobe
    typedef logic [1:0] dinSize;

    localparam dinSize sizeByte = 2'd0;
    localparam dinSize sizeHalf = 2'd1;
    localparam dinSize sizeWord = 2'd2;

    // master to memory, strobes are active low
    typedef struct packed {
        ramAddr addr;
        ramData din;
        dinSize size;
        logic   oeN;
        logic   weN;
        logic   rfshN;
    } ramReq;

    // memory to master
    typedef struct packed {
        ramData dout;
        logic   ackN;
        // single-cycle pulse when an access starts
        logic   timing;
    } ramRsp;

    // a silent master drives this; also the neutral value for OR/AND merging
    localparam ramReq reqIdle = '{
        addr:  '0,
        din:   '0,
        size:  sizeByte,
        oeN:   1'b1,
        weN:   1'b1,
        rfshN: 1'b1
    };

endpackage

// File: hdl/memCfgPkg.sv
// configuration package: master count, RAM depth, wait states, refresh counter type
package memCfgPkg;

    // number of masters sharing the port
    localparam int hostCount = 3;

    // RAM holds 2**wordAddrBits words
    // byte address bits above the word index are ignored
    localparam int wordAddrBits = 8;

    // cycles spent in the ACCESS state
    localparam int waitStates = 2;

    // refresh counter, wraps silently
    typedef logic [15:0] rfshCount;

endpackage

// number of refreshes seen since reset is exported at the top
// as a rfshCount value

// File: hdl/busMerge.sv
// busMerge: folds all master requests into one registered request, fans the registered response out
module busMerge (
    input  logic            CLK,
    input  logic            RESET_n,
    input  ramPkg::ramReq   hostReq [memCfgPkg::hostCount],
    output ramPkg::ramReq   memReq,
    input  ramPkg::ramRsp   memRsp,
    output ramPkg::ramRsp   hostRsp [memCfgPkg::hostCount]
);
    import ramPkg::*;
    import memCfgPkg::*;

    // combined request before the register stage
    ramReq merged;

    // response after the register stage, shared by every master
    ramRsp rspReg;

    // idle masters drive zeros and high strobes
    // so OR on payload and AND on strobes picks the active one
    always_comb begin
        merged = reqIdle;
        for (int i = 0; i < hostCount; i++) begin
            merged.addr  = merged.addr  | hostReq[i].addr;
            merged.din   = merged.din   | hostReq[i].din;
            merged.size  = merged.size  | hostReq[i].size;
            merged.oeN   = merged.oeN   & hostReq[i].oeN;
            merged.weN   = merged.weN   & hostReq[i].weN;
            merged.rfshN = merged.rfshN & hostReq[i].rfshN;
        end
    end

    // request side register
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            memReq <= reqIdle;
        end else begin
            memReq <= merged;
        end
    end

    // response side register
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            rspReg.dout   <= '0;
            rspReg.ackN   <= 1'b1;
            rspReg.timing <= 1'b0;
        end else begin
            rspReg <= memRsp;
        end
    end

    // every master gets the same copy
    // masters that are not accessing just ignore it
    always_comb begin
        for (int i = 0; i < hostCount; i++) begin
            hostRsp[i] = rspReg;
        end
    end

endmodule

// File: hdl/ramController.sv
// ramController: access FSM with wait states, byte-lane write decode, refresh counter, acknowledge hold
module ramController (
    input  logic                                CLK,
    input  logic                                RESET_n,
    input  ramPkg::ramReq                       memReq,
    output ramPkg::ramRsp                       memRsp,
    output logic                                we,
    output logic [3:0]                          byteEn,
    output logic [memCfgPkg::wordAddrBits-1:0]  wordAddr,
    output ramPkg::ramData                      wdata,
    input  ramPkg::ramData                      rdata,
    output memCfgPkg::rfshCount                 refreshes
);
    import ramPkg::*;
    import memCfgPkg::*;

    localparam int cntBits = $clog2(waitStates + 1);
    localparam logic [cntBits-1:0] waitLast = cntBits'(waitStates - 1);

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESPOND,
        RELEASE
    } ctrlState;

    ctrlState           state;
    // request captured when the access starts
    ramReq              reqLatch;
    logic [cntBits-1:0] waitCnt;
    logic               anyStrobe;
    logic               lastWait;
    logic               isRead;
    logic               isWrite;
    logic               isRefresh;

    assign anyStrobe = !(memReq.oeN && memReq.weN && memReq.rfshN);
    assign lastWait  = (waitCnt == waitLast);
    assign isRead    = !reqLatch.oeN;
    assign isWrite   = !reqLatch.weN;
    assign isRefresh = !reqLatch.rfshN;

    // word index, byte offset bits and upper address bits are dropped
    assign wordAddr = reqLatch.addr[wordAddrBits+1:2];

    // write strobe on the last ACCESS cycle only
    assign we = (state == ACCESS) && lastWait && isWrite;

    // lane decode, data shifted up to the addressed lanes
    always_comb begin
        case (reqLatch.size)
            sizeByte: begin
                byteEn = 4'b0001 << reqLatch.addr[1:0];
                wdata  = ramData'(reqLatch.din[7:0]) << {reqLatch.addr[1:0], 3'b000};
            end
            sizeHalf: begin
                // j is address bit 1, lanes 2j and 2j+1
                byteEn = 4'b0011 << {reqLatch.addr[1], 1'b0};
                wdata  = ramData'(reqLatch.din[15:0]) << {reqLatch.addr[1], 4'b0000};
            end
            default: begin
                byteEn = 4'b1111;
                wdata  = reqLatch.din;
            end
        endcase
    end

    // request latch, payload only
    always_ff @(posedge CLK) begin
        if (state == IDLE && anyStrobe) begin
            reqLatch <= memReq;
        end
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            state         <= IDLE;
            waitCnt       <= '0;
            memRsp.dout   <= '0;
            memRsp.ackN   <= 1'b1;
            memRsp.timing <= 1'b0;
            refreshes     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (anyStrobe) begin
                        memRsp.timing <= 1'b1;
                        waitCnt       <= '0;
                        state         <= ACCESS;
                    end
                end
                ACCESS: begin
                    // timing pulse ends after one cycle
                    memRsp.timing <= 1'b0;
                    if (lastWait) begin
                        state <= RESPOND;
                    end else begin
                        waitCnt <= waitCnt + 1'b1;
                    end
                end
                RESPOND: begin
                    // rdata is the registered read of the latched word
                    memRsp.ackN <= 1'b0;
                    memRsp.dout <= isRead ? rdata : '0;
                    if (isRefresh) begin
                        refreshes <= refreshes + 1'b1;
                    end
                    state <= RELEASE;
                end
                default: begin
                    // RELEASE: hold ack until the master lets go
                    if (!anyStrobe) begin
                        memRsp.ackN <= 1'b1;
                        memRsp.dout <= '0;
                        state       <= IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: hdl/ramArray.sv
// ramArray: synchronous word memory with byte-lane write enables and registered read
module ramArray (
    input  logic                                CLK,
    input  logic                                we,
    input  logic [3:0]                          byteEn,
    input  logic [memCfgPkg::wordAddrBits-1:0]  wordAddr,
    input  ramPkg::ramData                      wdata,
    output ramPkg::ramData                      rdata
);
    import ramPkg::*;
    import memCfgPkg::*;

    localparam int depth     = 2 ** wordAddrBits;
    localparam int laneCount = $bits(ramData) / 8;

    // storage, contents undefined until written
    ramData mem [depth];

    // write side
    // each lane written on its own enable
    always_ff @(posedge CLK) begin
        for (int lane = 0; lane < laneCount; lane++) begin
            if (we && byteEn[lane]) begin
                mem[wordAddr][8*lane +: 8] <= wdata[8*lane +: 8];
            end
        end
    end

    // read side
    // address sampled every cycle, old data returned on a same-cycle write
    always_ff @(posedge CLK) begin
        rdata <= mem[wordAddr];
    end

endmodule

// File: hdl/ramSubsystem.sv
// ramSubsystem: top level wiring of busMerge, ramController and ramArray
module ramSubsystem (
    input  logic                 CLK,
    input  logic                 RESET_n,
    input  ramPkg::ramReq        hostReq [memCfgPkg::hostCount],
    output ramPkg::ramRsp        hostRsp [memCfgPkg::hostCount],
    output memCfgPkg::rfshCount  refreshes
);
    import ramPkg::*;
    import memCfgPkg::*;

    // merged bus between merge stage and controller
    ramReq memReq;
    ramRsp memRsp;

    // controller to array
    logic                    we;
    logic [3:0]              byteEn;
    logic [wordAddrBits-1:0] wordAddr;
    ramData                  wdata;
    ramData                  rdata;

    busMerge u_busMerge (
        .CLK     (CLK),
        .RESET_n (RESET_n),
        .hostReq (hostReq),
        .memReq  (memReq),
        .memRsp  (memRsp),
        .hostRsp (hostRsp)
    );

    ramController u_ramController (
        .CLK       (CLK),
        .RESET_n   (RESET_n),
        .memReq    (memReq),
        .memRsp    (memRsp),
        .we        (we),
        .byteEn    (byteEn),
        .wordAddr  (wordAddr),
        .wdata     (wdata),
        .rdata     (rdata),
        .refreshes (refreshes)
    );

    ramArray u_ramArray (
        .CLK      (CLK),
        .we       (we),
        .byteEn   (byteEn),
        .wordAddr (wordAddr),
        .wdata    (wdata),
        .rdata    (rdata)
    );

endmodule

// File: test/ramSubsystem_checker.sv
// ramSubsystem_checker: concurrent assertions on the top-level ports, bound into ramSubsystem
module ramSubsystem_checker (
    input logic                 CLK,
    input logic                 RESET_n,
    input ramPkg::ramReq        hostReq [memCfgPkg::hostCount],
    input ramPkg::ramRsp        hostRsp [memCfgPkg::hostCount],
    input memCfgPkg::rfshCount  refreshes
);
    timeunit 1ns;
    timeprecision 100ps;
    import ramPkg::*;
    import memCfgPkg::*;

    // every strobe of every master is high
    logic allIdle;
    // all fanned-out responses match master 0
    logic rspSame;

    always_comb begin
        allIdle = 1'b1;
        rspSame = 1'b1;
        for (int i = 0; i < hostCount; i++) begin
            allIdle = allIdle & hostReq[i].oeN & hostReq[i].weN & hostReq[i].rfshN;
            rspSame = rspSame & (hostRsp[i] == hostRsp[0]);
        end
    end

    timingPulse: assert property (@(posedge CLK) disable iff (!RESET_n)
        hostRsp[0].timing |=> !hostRsp[0].timing)
        else $error("timing strobe high for more than one cycle");

    // no acknowledge may appear out of an idle bus
    ackQuiet: assert property (@(posedge CLK) disable iff (!RESET_n)
        (allIdle && hostRsp[0].ackN) |=> hostRsp[0].ackN)
        else $error("acknowledge fell while no strobe was active");

    rspFanout: assert property (@(posedge CLK) disable iff (!RESET_n) rspSame)
        else $error("response elements differ between masters");

    rfshMonotonic: assert property (@(posedge CLK) disable iff (!RESET_n)
        refreshes >= $past(refreshes))
        else $error("refresh count decreased");

endmodule

bind ramSubsystem ramSubsystem_checker u_ramSubsystemChecker (
    .CLK       (CLK),
    .RESET_n   (RESET_n),
    .hostReq   (hostReq),
    .hostRsp   (hostRsp),
    .refreshes (refreshes)
);

// File: test/ramSubsystem_tb.sv
// ramSubsystem_tb: clock, reset, stimulus table with reference memory model, checks, closing report
module ramSubsystem_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import ramPkg::*;
    import memCfgPkg::*;

    localparam int maxEntries = 32;
    localparam int ackTimeout = 40;
    localparam int opRead     = 0;
    localparam int opWrite    = 1;
    localparam int opRefresh  = 2;

    logic     CLK;
    logic     RESET_n;
    ramReq    hostReq [hostCount];
    ramRsp    hostRsp [hostCount];
    rfshCount refreshes;

    // stimulus table, one column per array
    string  tName [maxEntries];
    int     tHost [maxEntries];
    int     tOp   [maxEntries];
    ramAddr tAddr [maxEntries];
    dinSize tSize [maxEntries];
    ramData tData [maxEntries];
    ramData tExp  [maxEntries];
    int     entryCount;

    // byte-wide reference of the RAM contents
    logic [7:0] refMem [4 * (2 ** wordAddrBits)];
    // refreshes issued so far
    rfshCount   expRefreshes;
    integer     seed;
    int         errorCount;
    int         timeoutCount;
    bit         aborted;

    ramSubsystem u_ramSubsystem (
        .CLK       (CLK),
        .RESET_n   (RESET_n),
        .hostReq   (hostReq),
        .hostRsp   (hostRsp),
        .refreshes (refreshes)
    );

    always #10 CLK = ~CLK;

    // byte offset inside the RAM, upper address bits dropped
    function automatic int byteIndex(input ramAddr addr);
        return int'(addr[wordAddrBits+1:0]);
    endfunction

    function automatic ramData modelRead(input ramAddr addr);
        int base;
        base = byteIndex(addr) & ~3;
        return {refMem[base+3], refMem[base+2], refMem[base+1], refMem[base]};
    endfunction

    task automatic modelWrite(input ramAddr addr, input dinSize size, input ramData data);
        int offs;
        int base;
        offs = byteIndex(addr);
        base = offs & ~3;
        case (size)
            sizeByte: refMem[offs] = data[7:0];
            sizeHalf: begin
                // lanes 2j and 2j+1 with j from address bit 1
                base = base + (offs & 2);
                refMem[base]   = data[7:0];
                refMem[base+1] = data[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    refMem[base+i] = data[8*i +: 8];
                end
            end
        endcase
    endtask

    // expected read value taken from the model as the table is built
    task automatic addEntry(input string name, input int host, input int op,
                            input ramAddr addr, input dinSize size);
        ramData data;
        data = (op == opWrite) ? ramData'($random(seed)) : '0;
        if (op == opWrite) begin
            modelWrite(addr, size, data);
        end
        tName[entryCount] = name;
        tHost[entryCount] = host;
        tOp[entryCount]   = op;
        tAddr[entryCount] = addr;
        tSize[entryCount] = size;
        tData[entryCount] = data;
        tExp[entryCount]  = (op == opRead) ? modelRead(addr) : '0;
        entryCount++;
    endtask

    task automatic buildTable();
        entryCount = 0;
        addEntry("word_w_h0", 0, opWrite, 24'h000010, sizeWord);
        addEntry("word_w_h1", 1, opWrite, 24'h000020, sizeWord);
        addEntry("word_w_h2", 2, opWrite, 24'h000030, sizeWord);
        addEntry("word_r_h2", 2, opRead, 24'h000010, sizeWord);
        addEntry("word_r_h0", 0, opRead, 24'h000020, sizeWord);
        addEntry("word_r_h1", 1, opRead, 24'h000030, sizeWord);
        addEntry("lane_base", 0, opWrite, 24'h000040, sizeWord);
        for (int k = 0; k < 4; k++) begin
            addEntry($sformatf("byte_w_%0d", k), k % hostCount, opWrite,
                     ramAddr'(24'h40 + k), sizeByte);
            addEntry($sformatf("byte_r_%0d", k), (k + 1) % hostCount, opRead,
                     24'h000040, sizeWord);
        end
        addEntry("half_base", 1, opWrite, 24'h000050, sizeWord);
        for (int j = 0; j < 2; j++) begin
            addEntry($sformatf("half_w_%0d", j), j, opWrite, ramAddr'(24'h50 + 2 * j), sizeHalf);
            addEntry($sformatf("half_r_%0d", j), 2, opRead, 24'h000050, sizeWord);
        end
        addEntry("refresh_1", 1, opRefresh, 24'h000000, sizeByte);
        addEntry("after_rfsh", 2, opRead, 24'h000010, sizeWord);
        addEntry("refresh_2", 0, opRefresh, 24'h000000, sizeByte);
        addEntry("hi_addr_r", 0, opRead, 24'hAB0010, sizeWord);
        addEntry("hi_addr_w", 2, opWrite, 24'h5C0060, sizeWord);
        addEntry("hi_addr_rb", 1, opRead, 24'h000060, sizeWord);
    endtask

    task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            errorCount++;
        end
    endtask

    // one full strobe/acknowledge cycle, called 2 ns after a rising edge
    task automatic runAccess(input int n);
        ramReq    req;
        int       cycles;
        int       pulses;
        int       pulseAt;
        int       probe;
        req      = reqIdle;
        req.addr = tAddr[n];
        req.din  = tData[n];
        req.size = tSize[n];
        case (tOp[n])
            opRead:  req.oeN = 1'b0;
            opWrite: req.weN = 1'b0;
            default: req.rfshN = 1'b0;
        endcase
        // watch a different master than the one driving, checks the fan-out
        probe   = (tHost[n] + 1) % hostCount;
        hostReq[tHost[n]] = req;
        cycles  = 0;
        pulses  = 0;
        pulseAt = 0;
        while (hostRsp[probe].ackN && cycles < ackTimeout) begin
            @(posedge CLK);
            #2;
            cycles++;
            if (hostRsp[probe].timing) begin
                pulses++;
                pulseAt = cycles;
            end
        end
        if (hostRsp[probe].ackN) begin
            $display("%s: no acknowledge within %0d cycles", tName[n], ackTimeout);
            timeoutCount++;
            aborted = 1'b1;
            return;
        end
        checkValue({tName[n], "_ack_latency"}, waitStates + 4, cycles);
        checkValue({tName[n], "_timing_pulses"}, 1, pulses);
        checkValue({tName[n], "_timing_latency"}, 3, pulseAt);
        // model word on a read, zero on a write or refresh
        checkValue(tName[n], tExp[n], hostRsp[probe].dout);
        if (tOp[n] == opRefresh) begin
            expRefreshes = expRefreshes + 1'b1;
            checkValue({tName[n], "_count"}, expRefreshes, refreshes);
        end
        // acknowledge must stay low while the request is held
        for (int h = 0; h < 2; h++) begin
            @(posedge CLK);
            #2;
            if (hostRsp[probe].ackN) begin
                $display("%s: acknowledge rose while the request was held", tName[n]);
                errorCount++;
            end
        end
        hostReq[tHost[n]] = reqIdle;
        cycles = 0;
        while (!hostRsp[probe].ackN && cycles < ackTimeout) begin
            @(posedge CLK);
            #2;
            cycles++;
        end
        if (!hostRsp[probe].ackN) begin
            $display("%s: acknowledge not released within %0d cycles", tName[n], ackTimeout);
            timeoutCount++;
            aborted = 1'b1;
            return;
        end
        checkValue({tName[n], "_release_latency"}, 3, cycles);
    endtask

    initial begin
        CLK          = 1'b0;
        RESET_n      = 1'b0;
        seed         = 3580;
        errorCount   = 0;
        timeoutCount = 0;
        aborted      = 1'b0;
        expRefreshes = '0;
        for (int i = 0; i < hostCount; i++) begin
            hostReq[i] = reqIdle;
        end
        buildTable();
        repeat (8) @(posedge CLK);
        #2;
        RESET_n = 1'b1;
        // reset state of every response copy
        for (int i = 0; i < hostCount; i++) begin
            checkValue($sformatf("reset_ack_%0d", i), 1, hostRsp[i].ackN);
            checkValue($sformatf("reset_timing_%0d", i), 0, hostRsp[i].timing);
        end
        checkValue("reset_refreshes", 0, refreshes);
        for (int n = 0; n < entryCount && !aborted; n++) begin
            runAccess(n);
        end
        $display("closing: %0d errors, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: sources.f
hdl/ramPkg.sv
hdl/memCfgPkg.sv
hdl/busMerge.sv
hdl/ramController.sv
hdl/ramArray.sv
hdl/ramSubsystem.sv
test/ramSubsystem_checker.sv
test/ramSubsystem_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert
TOP       = ramSubsystem_tb
FILELIST  = sources.f
OBJDIR    = obj_dir
LOG       = sim.log

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Done: errors found" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
